/* logic/ice_pkg.sv */
package ice_pkg;

	// host opcodes, first byte of every two-byte command
	typedef enum logic [7:0] {
		op_led  = 8'h4c, // 'L' data byte goes to the debug leds
		op_pint = 8'h50  // 'P' data byte goes out as a pint frame
	} opcode_e;

	// command parser
	typedef enum logic {
		wait_op,
		wait_data
	} cmd_state_e;

	// button k reports button_code_base + k
	localparam logic [7:0] button_code_base = 8'h80;

endpackage

/* logic/pint_pkg.sv */
package pint_pkg;

	// tag (2) then data (8), msb first
	localparam int frame_bits = 10;

	// frame source tag
	typedef enum logic [1:0] {
		tag_host   = 2'b01,
		tag_button = 2'b10
	} tag_e;

	// serializer states
	typedef enum logic [1:0] {
		idle,
		shift,
		gap
	} tx_state_e;

endpackage

/* logic/debounce_ms.sv */
module debounce_ms #(
	parameter int num_buttons = 3,
	parameter int db_cycles = 50000
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [num_buttons-1:0] db_in,
	output logic [num_buttons-1:0] db_out
);

	localparam int cw = $clog2(db_cycles + 1);

	logic [cw-1:0] stable_cnt [num_buttons]; // one stability counter per bit

	always_ff @(posedge clk) begin
		if (reset) begin
			db_out <= '0;
			for (int i = 0; i < num_buttons; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_buttons; i++) begin
				if (db_in[i] != db_out[i]) begin
					if (stable_cnt[i] == cw'(db_cycles)) begin
						db_out[i]     <= db_in[i]; // held long enough, take it
						stable_cnt[i] <= '0;
					end else begin
						stable_cnt[i] <= stable_cnt[i] + 1'b1;
					end
				end else begin
					stable_cnt[i] <= '0; // glitch went away, start over
				end
			end
		end
	end

endmodule

/* logic/uart_rx.sv */
module uart_rx #(
	parameter int clks_per_bit = 868
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rxd,
	output logic       rx_valid,
	output logic [7:0] rx_data
);

	localparam int cw   = $clog2(clks_per_bit);
	localparam int half = clks_per_bit / 2;

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_bits,
		s_stop
	} rx_state_e;

	rx_state_e state;
	logic [cw-1:0] bit_timer;
	logic [2:0] bit_idx;
	logic rxd_meta, rxd_sync; // two-flop synchronizer

	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_meta <= 1'b1; // line idles high
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	// ########################################################################
	// bit timing, sample at the middle of each bit
	// ########################################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= s_idle;
			bit_timer <= '0;
			bit_idx   <= '0;
			rx_valid  <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				s_idle: begin
					bit_timer <= '0;
					if (!rxd_sync)
						state <= s_start; // falling edge of start bit
				end
				s_start: begin
					if (bit_timer == cw'(half - 1)) begin
						bit_timer <= '0;
						bit_idx   <= '0;
						state     <= rxd_sync ? s_idle : s_bits; // false start if high again
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				s_bits: begin
					if (bit_timer == cw'(clks_per_bit - 1)) begin
						bit_timer <= '0;
						bit_idx   <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= s_stop;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				default: begin // s_stop
					if (bit_timer == cw'(clks_per_bit - 1)) begin
						rx_valid <= rxd_sync; // low stop bit means framing error, drop it
						state    <= s_idle;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == s_bits && bit_timer == cw'(clks_per_bit - 1))
			rx_data <= {rxd_sync, rx_data[7:1]};
	end

	// a byte takes ten bit times, the strobe can never repeat back to back
	a_single_strobe: assert property (@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

/* logic/pint_tx.sv */
module pint_tx #(
	parameter int pint_div = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              tx_start,
	input  pint_pkg::tag_e    tx_tag,
	input  logic [7:0]        tx_data,
	output logic              tx_busy,
	output logic              pint_wrreq,
	output logic              pint_wrdata,
	output logic              pint_clk
);

	localparam int cw = $clog2(2 * pint_div);
	localparam int bw = $clog2(pint_pkg::frame_bits);

	pint_pkg::tx_state_e state;
	logic [pint_pkg::frame_bits-1:0] shreg;
	logic [cw-1:0] div_cnt;
	logic [bw-1:0] bit_cnt;

	assign tx_busy     = (state != pint_pkg::idle);
	assign pint_wrdata = pint_wrreq & shreg[pint_pkg::frame_bits-1]; // held low when idle

	// ########################################################################
	// frame state machine and pint_clk divider
	// ########################################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= pint_pkg::idle;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			pint_clk   <= 1'b0;
			pint_wrreq <= 1'b0;
		end else begin
			case (state)
				pint_pkg::idle: begin
					div_cnt  <= '0;
					bit_cnt  <= '0;
					pint_clk <= 1'b0;
					if (tx_start) begin
						state      <= pint_pkg::shift;
						pint_wrreq <= 1'b1;
					end
				end
				pint_pkg::shift: begin
					if (div_cnt == cw'(pint_div - 1)) begin
						div_cnt  <= '0;
						pint_clk <= !pint_clk;
						if (pint_clk) begin // falling edge, next bit
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == bw'(pint_pkg::frame_bits - 1)) begin
								state      <= pint_pkg::gap;
								pint_wrreq <= 1'b0;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: begin // gap between frames
					if (div_cnt == cw'(2 * pint_div - 1))
						state <= pint_pkg::idle;
					else
						div_cnt <= div_cnt + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == pint_pkg::idle && tx_start)
			shreg <= {tx_tag, tx_data};
		else if (state == pint_pkg::shift && div_cnt == cw'(pint_div - 1) && pint_clk)
			shreg <= {shreg[pint_pkg::frame_bits-2:0], 1'b0};
	end

	a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !tx_busy);

	a_wrreq_in_shift: assert property (@(posedge clk) disable iff (reset)
		(state == pint_pkg::shift) |-> pint_wrreq);

endmodule

/* logic/ice_cmd.sv */
module ice_cmd #(
	parameter int num_buttons = 3
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rx_valid,
	input  logic [7:0]             rx_data,
	input  logic [num_buttons-1:0] btn_level,
	input  logic                   tx_busy,
	output logic                   tx_start,
	output pint_pkg::tag_e         tx_tag,
	output logic [7:0]             tx_data,
	output logic [7:0]             led
);

	localparam int first_button = 2; // btn_level[0] is PB2

	ice_pkg::cmd_state_e state;
	ice_pkg::opcode_e op_q;

	logic [num_buttons-1:0] btn_prev;
	logic [num_buttons-1:0] btn_rise;
	logic press_hit;
	logic [7:0] press_code;

	logic host_full, btn_full; // one holding slot per source
	logic [7:0] host_data, btn_data;
	logic host_store;

	assign btn_rise = btn_level & ~btn_prev;

	// lowest newly pressed button wins
	always_comb begin
		press_hit  = 1'b0;
		press_code = '0;
		for (int i = num_buttons - 1; i >= 0; i--) begin
			if (btn_rise[i]) begin
				press_hit  = 1'b1;
				press_code = ice_pkg::button_code_base + 8'(i + first_button);
			end
		end
	end

	assign host_store = rx_valid && state == ice_pkg::wait_data && op_q == ice_pkg::op_pint;

	// ########################################################################
	// host command parser
	// ########################################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ice_pkg::wait_op;
			led   <= '0;
		end else if (rx_valid) begin
			if (state == ice_pkg::wait_op) begin
				state <= ice_pkg::wait_data;
			end else begin
				state <= ice_pkg::wait_op; // unknown opcodes still eat their data byte
				if (op_q == ice_pkg::op_led)
					led <= rx_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid && state == ice_pkg::wait_op)
			op_q <= ice_pkg::opcode_e'(rx_data);
	end

	// ########################################################################
	// holding slots and serializer arbitration
	// ########################################################################
	always_ff @(posedge clk) begin
		if (reset) begin
			btn_prev  <= '0;
			host_full <= 1'b0;
			btn_full  <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			btn_prev <= btn_level;
			tx_start <= 1'b0;
			if (host_store && !host_full)
				host_full <= 1'b1; // dropped if already full
			if (press_hit && !btn_full)
				btn_full <= 1'b1;
			// tx_busy lags tx_start by one cycle, so skip the cycle after a start
			if (!tx_busy && !tx_start) begin
				if (btn_full) begin
					tx_start <= 1'b1;
					btn_full <= 1'b0; // button frames go first
				end else if (host_full) begin
					tx_start  <= 1'b1;
					host_full <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (host_store && !host_full)
			host_data <= rx_data;
		if (press_hit && !btn_full)
			btn_data <= press_code;
		if (!tx_busy && !tx_start && (btn_full || host_full)) begin
			tx_tag  <= btn_full ? pint_pkg::tag_button : pint_pkg::tag_host;
			tx_data <= btn_full ? btn_data : host_data;
		end
	end

	// the serializer must be idle and must pick the frame up on the next cycle
	a_start_handshake: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !tx_busy ##1 tx_busy);

endmodule

/* logic/m3_ice_top.sv */
module m3_ice_top #(
	parameter int clks_per_bit = 868,
	parameter int db_cycles = 50000,
	parameter int pint_div = 8,
	parameter int num_buttons = 3
) (
	input  logic       sys_clk,
	input  logic       reset,
	input  logic [4:1] pb,           // active low, pb[1] not used here
	input  logic       usb_uart_txd,
	output logic [7:0] led,
	output logic       pint_resetn,
	output logic       pint_wrreq,
	output logic       pint_wrdata,
	output logic       pint_clk
);

	logic [num_buttons-1:0] btn_level;
	logic rx_valid;
	logic [7:0] rx_data;
	logic tx_start, tx_busy;
	pint_pkg::tag_e tx_tag;
	logic [7:0] tx_data;

	// pint target held in reset until one cycle after ours
	always_ff @(posedge sys_clk) begin
		if (reset)
			pint_resetn <= 1'b0;
		else
			pint_resetn <= 1'b1;
	end

	debounce_ms #(
		.num_buttons(num_buttons),
		.db_cycles  (db_cycles)
	) i_debounce_ms (
		.clk   (sys_clk),
		.reset (reset),
		.db_in (~pb[num_buttons+1:2]), // pressed reads as 1
		.db_out(btn_level)
	);

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) i_uart_rx (
		.clk     (sys_clk),
		.reset   (reset),
		.rxd     (usb_uart_txd),
		.rx_valid(rx_valid),
		.rx_data (rx_data)
	);

	ice_cmd #(
		.num_buttons(num_buttons)
	) i_ice_cmd (
		.clk      (sys_clk),
		.reset    (reset),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.btn_level(btn_level),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_tag   (tx_tag),
		.tx_data  (tx_data),
		.led      (led)
	);

	pint_tx #(
		.pint_div(pint_div)
	) i_pint_tx (
		.clk        (sys_clk),
		.reset      (reset),
		.tx_start   (tx_start),
		.tx_tag     (tx_tag),
		.tx_data    (tx_data),
		.tx_busy    (tx_busy),
		.pint_wrreq (pint_wrreq),
		.pint_wrdata(pint_wrdata),
		.pint_clk   (pint_clk)
	);

endmodule

/* verification/m3_ice_tb.sv */
module m3_ice_tb;

	localparam int clks_per_bit = 16;
	localparam int db_cycles = 40;
	localparam int pint_div = 2;
	localparam int num_buttons = 3;
	localparam int fb = pint_pkg::frame_bits;

	// watchdog limit worked out from the traffic the test sends
	localparam int n_bytes = 22;
	localparam int n_frames = 10;
	localparam int n_holds = 6; // five presses and a spare
	localparam int hold_cycles = db_cycles + 20;
	localparam int byte_cycles = 11 * clks_per_bit; // ten bits plus one idle bit
	localparam int frame_cycles = fb * 2 * pint_div + 2 * pint_div + 4;
	localparam int cycle_limit = 2 * (16 + n_bytes * byte_cycles + n_frames * frame_cycles
		+ n_holds * 2 * hold_cycles);

	logic clk;
	logic reset;
	logic [4:1] pb;
	logic usb_uart_txd;
	logic [7:0] led;
	logic pint_resetn, pint_wrreq, pint_wrdata, pint_clk;

	logic [fb-1:0] exp_q[$]; // frames the model expects
	logic [fb-1:0] got_q[$]; // frames seen on the pint pins
	logic [fb-1:0] cap_shift;
	logic pint_clk_q;
	logic any_order = 1'b0;
	logic [7:0] led_model = '0;
	int cap_bits = 0;
	int frame_count = 0;
	int expected_count = 0;
	int cycle_count = 0;

	m3_ice_top #(
		.clks_per_bit(clks_per_bit),
		.db_cycles   (db_cycles),
		.pint_div    (pint_div),
		.num_buttons (num_buttons)
	) i_m3_ice_top (
		.sys_clk     (clk),
		.reset       (reset),
		.pb          (pb),
		.usb_uart_txd(usb_uart_txd),
		.led         (led),
		.pint_resetn (pint_resetn),
		.pint_wrreq  (pint_wrreq),
		.pint_wrdata (pint_wrdata),
		.pint_clk    (pint_clk)
	);

	always #2 clk = ~clk;

	// tag in the top two bits above the data byte
	function automatic logic [fb-1:0] expected_frame(input pint_pkg::tag_e source,
		input logic [7:0] data);
		expected_frame = {source, data};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1; // inputs change just after the edge
	endtask

	// 8N1 framing with the lsb first
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			usb_uart_txd = bits[i];
			tick(clks_per_bit);
		end
		tick(clks_per_bit); // idle bit so that rx_valid has come by now
	endtask

	task automatic send_command(input logic [7:0] op, input logic [7:0] data);
		send_byte(op);
		send_byte(data);
	endtask

	task automatic press_button(input int k, input int cycles);
		pb[k] = 1'b0; // active low
		tick(cycles);
		pb[k] = 1'b1;
		tick(hold_cycles); // let the debounced level drop again
	endtask

	task automatic queue_frame(input pint_pkg::tag_e source, input logic [7:0] data);
		exp_q.push_back(expected_frame(source, data));
		expected_count++;
	endtask

	task automatic wait_frames;
		while (exp_q.size() != 0)
			tick(1);
	endtask

	// ########################################################################
	// pint capture, compare and watchdog
	// ########################################################################
	always @(negedge clk) begin
		if (reset) begin
			cap_bits = 0;
		end else if (pint_wrreq && pint_clk && !pint_clk_q) begin
			cap_shift = {cap_shift[fb-2:0], pint_wrdata}; // receiver samples on the rise
			cap_bits++;
			if (cap_bits == fb) begin
				got_q.push_back(cap_shift);
				cap_bits = 0;
			end
		end
		pint_clk_q = pint_clk;
	end

	always @(posedge clk) begin
		logic [fb-1:0] got;
		int idx;
		while (got_q.size() != 0) begin
			got = got_q.pop_front();
			frame_count++;
			check_value(32'(exp_q.size() != 0), 1, "pint frame with none expected");
			idx = 0;
			if (any_order) begin
				for (int i = 0; i < exp_q.size(); i++) begin
					if (exp_q[i] == got)
						idx = i;
				end
			end
			check_value(32'(got), 32'(exp_q[idx]), "pint frame");
			exp_q.delete(idx);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("ERRORS FOUND");
			$fatal(1, "timeout: run did not finish");
		end
	end

	// ########################################################################
	// test sequence
	// ########################################################################
	initial begin
		int order [3];
		int j, k, tmp;
		logic [7:0] d, op;
		void'($urandom(32'hbba9a471));
		clk = 1'b0;
		reset = 1'b1;
		pb = 4'hf;
		usb_uart_txd = 1'b1;

		tick(4);
		check_value(32'(led), 0, "led in reset");
		check_value(32'(pint_wrreq), 0, "pint_wrreq in reset");
		check_value(32'(pint_resetn), 0, "pint_resetn in reset");
		tick(12);
		reset = 1'b0;
		tick(2);
		check_value(32'(led), 0, "led after reset");
		check_value(32'(pint_wrreq), 0, "pint_wrreq after reset");
		check_value(32'(pint_resetn), 1, "pint_resetn after reset");

		for (int i = 0; i < 4; i++) begin
			d = 8'($urandom);
			send_command(ice_pkg::op_led, d);
			led_model = d;
			check_value(32'(led), 32'(led_model), "led after op_led");
		end

		for (int i = 0; i < 4; i++) begin
			d = 8'($urandom);
			queue_frame(pint_pkg::tag_host, d);
			send_command(ice_pkg::op_pint, d);
			wait_frames();
			tick(frame_cycles); // a second frame would show up in here
			check_value(32'(frame_count), 32'(expected_count), "frames after op_pint");
		end

		order = '{2, 3, 4};
		for (int i = 2; i > 0; i--) begin // shuffle the press order
			j = int'($urandom % 32'(i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 3; i++) begin
			queue_frame(pint_pkg::tag_button, ice_pkg::button_code_base + 8'(order[i]));
			press_button(order[i], hold_cycles);
			wait_frames();
		end
		k = 2 + int'($urandom % 3);
		press_button(k, db_cycles / 2); // too short to report

		do
			op = 8'($urandom);
		while (op == ice_pkg::op_led || op == ice_pkg::op_pint);
		send_command(op, 8'($urandom));
		tick(frame_cycles); // long enough for a stray frame to arrive
		check_value(32'(led), 32'(led_model), "led after unknown opcode");
		check_value(32'(frame_count), 32'(expected_count), "frames after unknown opcode");
		d = 8'($urandom);
		queue_frame(pint_pkg::tag_host, d);
		send_command(ice_pkg::op_pint, d);
		wait_frames();

		// host and button frames land close together
		any_order = 1'b1;
		k = 2 + int'($urandom % 3);
		d = 8'($urandom);
		queue_frame(pint_pkg::tag_host, d);
		queue_frame(pint_pkg::tag_button, ice_pkg::button_code_base + 8'(k));
		fork
			send_command(ice_pkg::op_pint, d);
			begin
				tick(290); // debounced press near the data byte strobe
				press_button(k, hold_cycles);
			end
		join
		wait_frames();

		tick(2 * frame_cycles); // room for a stray frame to show up
		check_value(32'(frame_count), 32'(expected_count), "total frame count");
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* tb.f */
logic/ice_pkg.sv
logic/pint_pkg.sv
logic/debounce_ms.sv
logic/uart_rx.sv
logic/pint_tx.sv
logic/ice_cmd.sv
logic/m3_ice_top.sv
verification/m3_ice_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator and run; a $fatal in the run gives a failing exit status
cd "$(dirname "$0")" && \
verilator --binary --assert --top-module m3_ice_tb -f tb.f && \
./obj_dir/Vm3_ice_tb || \
{ echo "simulation failed"; exit 1; }
exit 0
